// File: Bender.yml
package:
  name: dot_engine

sources:
  - files:
      - hdl/dot_pkg.sv
      - hdl/amul_bw16.sv
      - hdl/dot_ctrl.sv
      - hdl/beat_counter.sv
      - hdl/mac_accum.sv
      - hdl/dot_engine_top.sv
  - target: simulation
    files:
      - verif/dot_checker.sv
      - verif/tb_dot_engine.sv

// File: hdl/amul_bw16.sv
`timescale 1ns/1ps

module amul_bw16 (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  dot_pkg::operand_t          in,
    output logic                       out_valid,
    output logic [dot_pkg::prod_w-1:0] product
);

    dot_pkg::operand_t op_q;
    logic              valid_q;
    logic [16:0]       pp [16];
    logic [20:0]       corr [4];
    logic [31:0]       exact_sum;
    logic [31:0]       corr_sum;
    logic [31:0]       exact_q;
    logic [31:0]       corr_q;
    logic              sum_valid_q;

    // Baugh-Wooley rows. Row i holds y weighted by x[i], with sign bits inverted.
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            pp[i][14:0] = op_q.y[14:0] & {15{op_q.x[i]}};
            pp[i][15]   = ~(op_q.y[15] & op_q.x[i]);
            pp[i][16]   = 1'b0;
        end
        pp[15][14:0] = ~(op_q.y[14:0] & {15{op_q.x[15]}});
        pp[15][15]   = op_q.y[15] & op_q.x[15];
        pp[0][16]    = 1'b1;
        pp[15][16]   = 1'b1;
    end

    // Rows 0 to 5 are only seen through these sparse vectors.
    always_comb begin
        corr[0] = '0;
        corr[1] = '0;
        corr[2] = '0;
        corr[3] = '0;

        corr[0][3]  = pp[0][2] & pp[1][1];
        corr[0][5]  = pp[4][1] ^ pp[5][0];
        corr[0][6]  = pp[2][3] & pp[3][2];
        corr[0][7]  = pp[0][7] ^ pp[1][6];
        corr[0][8]  = pp[0][7] & pp[1][6];
        corr[0][10] = pp[2][7] & pp[3][6];
        corr[0][12] = pp[0][11] & pp[1][10];
        corr[0][14] = pp[0][13] & pp[1][12];
        corr[0][16] = pp[0][15] & pp[1][14];
        corr[0][17] = pp[1][15];
        corr[0][18] = pp[2][15] & pp[3][14];
        corr[0][19] = pp[4][14] & pp[5][13];
        corr[0][20] = pp[4][15] & pp[5][14];

        corr[1][3]  = pp[0][3] ^ pp[1][2];
        corr[1][7]  = pp[2][4] & pp[3][3];
        corr[1][8]  = pp[0][8] ^ pp[1][7];
        corr[1][10] = pp[2][8] ^ pp[3][7];
        corr[1][14] = pp[2][11] & pp[3][10];
        corr[1][17] = pp[2][15] | pp[3][14];
        corr[1][18] = pp[3][15];
        corr[1][19] = pp[4][15] ^ pp[5][14];
        corr[1][20] = pp[5][15];

        corr[2][10] = pp[4][6] ^ pp[5][5];
        corr[2][14] = pp[4][10] ^ pp[5][9];
        corr[2][17] = pp[2][15] ^ pp[3][14];
        corr[2][18] = pp[4][13] & pp[5][12];

        corr[3][17] = pp[4][13] ^ pp[5][12];
        corr[3][18] = pp[4][14] ^ pp[5][13];
    end

    // Upper rows are summed exactly, modulo 2^32.
    always_comb begin
        exact_sum = '0;
        for (int i = 6; i < 16; i++) begin
            exact_sum = exact_sum + ({15'b0, pp[i]} << i);
        end
        corr_sum = {11'b0, corr[0]} + {11'b0, corr[1]} + {11'b0, corr[2]} + {11'b0, corr[3]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            sum_valid_q <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            valid_q     <= in_valid;
            sum_valid_q <= valid_q;
            out_valid   <= sum_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q <= in;
        end
        exact_q <= exact_sum;
        corr_q  <= corr_sum;
        product <= exact_q + corr_q;
    end

endmodule

// File: hdl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter #(
    parameter int LEN_W = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic [LEN_W-1:0] len,
    input  logic             beat,
    output logic             last_beat,
    input  logic             drain_start,
    output logic             drain_done,
    output logic [LEN_W-1:0] beats
);

    // Remaining beats while accumulating, then the drain timer.
    logic [LEN_W-1:0] remain;
    logic             drain_busy;

    assign last_beat  = ~drain_busy && (remain == LEN_W'(1));
    assign drain_done = drain_busy && (remain == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (load) begin
            remain <= len;
        end else if (drain_start) begin
            remain <= LEN_W'(dot_pkg::drain_cycles - 1);
        end else if (beat || (drain_busy && remain != '0)) begin
            remain <= remain - LEN_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_busy <= 1'b0;
        end else if (drain_start) begin
            drain_busy <= 1'b1;
        end else if (drain_done) begin
            drain_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beats <= '0;
        end else if (load) begin
            beats <= '0;
        end else if (beat) begin
            beats <= beats + LEN_W'(1);
        end
    end

endmodule

// File: hdl/dot_ctrl.sv
`timescale 1ns/1ps

module dot_ctrl #(
    parameter int LEN_W = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    output logic             req_ready,
    input  logic [LEN_W-1:0] req_len,
    input  logic             op_valid,
    output logic             op_ready,
    output logic             op_fire,
    output logic             cnt_load,
    output logic [LEN_W-1:0] cnt_len,
    input  logic             last_beat,
    input  logic             drain_done,
    output logic             acc_clear,
    output logic             res_valid,
    input  logic             res_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_accum,
        st_drain,
        st_result
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [LEN_W-1:0] len_q;
    logic             req_fire;

    assign req_fire  = req_valid && req_ready;
    assign op_ready  = (state == st_accum);
    assign op_fire   = op_valid && op_ready;
    assign res_valid = (state == st_result);

    // The load cycle restarts both the beat counter and the accumulator.
    assign cnt_load  = (state == st_load);
    assign acc_clear = (state == st_load);
    assign cnt_len   = len_q;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_fire) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                state_next = st_accum;
            end
            st_accum: begin
                if (op_fire && last_beat) begin
                    state_next = st_drain;
                end
            end
            st_drain: begin
                if (drain_done) begin
                    state_next = st_result;
                end
            end
            st_result: begin
                if (res_ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // req_ready follows the next state, so it first rises one cycle after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            req_ready <= 1'b0;
            len_q     <= '0;
        end else begin
            state     <= state_next;
            req_ready <= (state_next == st_idle);
            if (req_fire) begin
                len_q <= req_len;
            end
        end
    end

endmodule

// File: hdl/dot_engine_top.sv
`timescale 1ns/1ps

module dot_engine_top #(
    parameter int ACC_W = dot_pkg::sum_w,
    parameter int LEN_W = dot_pkg::len_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  dot_pkg::job_req_t req,
    input  logic              op_valid,
    output logic              op_ready,
    input  dot_pkg::operand_t op,
    output logic              res_valid,
    input  logic              res_ready,
    output dot_pkg::result_t  res
);

    logic                       op_fire;
    logic                       cnt_load;
    logic [LEN_W-1:0]           cnt_len;
    logic                       last_beat;
    logic                       drain_start;
    logic                       drain_done;
    logic [LEN_W-1:0]           beats;
    logic                       acc_clear;
    logic                       prod_valid;
    logic [dot_pkg::prod_w-1:0] product;
    logic [ACC_W-1:0]           acc_sum;

    // The drain timer starts with the final operand transfer.
    assign drain_start = op_fire & last_beat;

    assign res.sum   = acc_sum;
    assign res.beats = beats;

    dot_ctrl #(
        .LEN_W(LEN_W)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_len   (req.len),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_fire   (op_fire),
        .cnt_load  (cnt_load),
        .cnt_len   (cnt_len),
        .last_beat (last_beat),
        .drain_done(drain_done),
        .acc_clear (acc_clear),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    beat_counter #(
        .LEN_W(LEN_W)
    ) u_count (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (cnt_load),
        .len        (cnt_len),
        .beat       (op_fire),
        .last_beat  (last_beat),
        .drain_start(drain_start),
        .drain_done (drain_done),
        .beats      (beats)
    );

    amul_bw16 u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (op_fire),
        .in       (op),
        .out_valid(prod_valid),
        .product  (product)
    );

    mac_accum #(
        .ACC_W(ACC_W)
    ) u_acc (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (acc_clear),
        .in_valid(prod_valid),
        .product (product),
        .sum     (acc_sum)
    );

endmodule

// File: hdl/dot_pkg.sv
package dot_pkg;

    // Operand and product widths of the approximate multiplier.
    localparam int op_w = 16;
    localparam int prod_w = 32;

    // Default job length and accumulator widths.
    localparam int len_w = 8;
    localparam int sum_w = 40;

    // Cycles the engine waits after the last beat before the sum is final.
    // This must cover the multiplier pipeline plus the accumulator add.
    localparam int drain_cycles = 3;

    // Job request: number of operand pairs in the vector, 1 or more.
    typedef struct packed {
        logic [len_w-1:0] len;
    } job_req_t;

    // One signed operand pair.
    typedef struct packed {
        logic signed [op_w-1:0] x;
        logic signed [op_w-1:0] y;
    } operand_t;

    // Job result: wrapped dot product and the number of beats taken.
    typedef struct packed {
        logic signed [sum_w-1:0] sum;
        logic [len_w-1:0]        beats;
    } result_t;

endpackage

// File: hdl/mac_accum.sv
`timescale 1ns/1ps

module mac_accum #(
    parameter int ACC_W = 40
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clear,
    input  logic                              in_valid,
    input  logic signed [dot_pkg::prod_w-1:0] product,
    output logic signed [ACC_W-1:0]           sum
);

    logic signed [ACC_W-1:0] product_ext;

    // Sign-extend to the accumulator width. The add itself wraps.
    assign product_ext = {{(ACC_W - dot_pkg::prod_w){product[dot_pkg::prod_w-1]}}, product};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;
        end else if (in_valid) begin
            sum <= sum + product_ext;
        end
    end

endmodule

// File: list.f
hdl/dot_pkg.sv
hdl/amul_bw16.sv
hdl/dot_ctrl.sv
hdl/beat_counter.sv
hdl/mac_accum.sv
hdl/dot_engine_top.sv
verif/dot_checker.sv
verif/tb_dot_engine.sv

// File: verif/dot_checker.sv
`timescale 1ns/1ps

module dot_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input logic              req_ready,
    input dot_pkg::job_req_t req,
    input logic              op_valid,
    input logic              op_ready,
    input dot_pkg::operand_t op,
    input logic              res_valid,
    input logic              res_ready,
    input dot_pkg::result_t  res
);

    string                      test_name = "reset_state";
    int                         error_count = 0;
    int                         results_checked = 0;
    logic [dot_pkg::sum_w-1:0]  exp_sum = '0;
    logic [dot_pkg::len_w-1:0]  exp_len = '0;
    int                         since_reset = 0;
    bit                         res_waiting = 1'b0;
    dot_pkg::result_t           res_held;
    logic [dot_pkg::prod_w-1:0] prod;

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        error_count++;
    endtask

    task automatic check_result();
        results_checked++;
        if (res.sum !== exp_sum) begin
            $display("[ERROR] %s: sum expected %0d actual %0d",
                     test_name, $signed(exp_sum), res.sum);
            error_count++;
        end
        if (res.beats !== exp_len) begin
            $display("[ERROR] %s: beats expected %0d actual %0d",
                     test_name, exp_len, res.beats);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            since_reset = 0;
            res_waiting = 1'b0;
            if (req_ready || op_ready || res_valid) begin
                report_failure("a ready or valid output was high during reset");
            end
        end else begin
            if (since_reset < 3) since_reset++;
            if (since_reset == 2 && !req_ready) begin
                report_failure("req_ready was not high one cycle after reset");
            end
            if (req_valid && req_ready) begin
                exp_sum = '0;
                exp_len = req.len;
            end
            if (op_valid && op_ready) begin
                prod = tb_dot_engine.ref_amul(op.x, op.y);
                exp_sum = exp_sum + {{(dot_pkg::sum_w - dot_pkg::prod_w){prod[31]}}, prod};
            end
            if (res_valid) begin
                if (op_ready) report_failure("operand channel open while a result is pending");
                if (res_waiting && res !== res_held) begin
                    report_failure("result changed while res_ready was low");
                end
                if (res_ready) begin
                    check_result();
                    res_waiting = 1'b0;
                end else begin
                    res_waiting = 1'b1;
                    res_held    = res;
                end
            end else if (res_waiting) begin
                report_failure("res_valid dropped before the result was taken");
                res_waiting = 1'b0;
            end
        end
    end

endmodule

// File: verif/tb_dot_engine.sv
`timescale 1ns/1ps

module tb_dot_engine;

    localparam int timeout_cycles = 2000;
    localparam int op_and = 0;
    localparam int op_xor = 1;
    localparam int op_or  = 2;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req_valid;
    logic              req_ready;
    dot_pkg::job_req_t req;
    logic              op_valid;
    logic              op_ready;
    dot_pkg::operand_t op;
    logic              res_valid;
    logic              res_ready;
    dot_pkg::result_t  res;

    logic [31:0]       rng_state = 32'hd34b_7121;
    dot_pkg::operand_t job_ops [$];
    bit                timed_out = 1'b0;
    int                jobs_done = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                errors_at_start = 0;
    string             cur_test = "reset_state";

    always #5 clk = ~clk;

    dot_engine_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res      (res)
    );

    dot_checker chk0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res      (res)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Baugh-Wooley row i, bit j. Sign-weighted bits are inverted, ones sit at bit 16.
    function automatic logic row_bit(input logic [15:0] x, input logic [15:0] y,
                                     input int i, input int j);
        logic b;
        if (j == 16) begin
            b = (i == 0) || (i == 15);
        end else if (i == 15 && j == 15) begin
            b = x[15] & y[15];
        end else if (i == 15 || j == 15) begin
            b = ~(x[i] & y[j]);
        end else begin
            b = x[i] & y[j];
        end
        return b;
    endfunction

    function automatic logic [31:0] corr_term(input int pos, input int op_sel,
                                              input logic a, input logic b);
        logic v;
        case (op_sel)
            op_and:  v = a & b;
            op_xor:  v = a ^ b;
            default: v = a | b;
        endcase
        return {31'b0, v} << pos;
    endfunction

    function automatic logic [31:0] ref_amul(input logic [15:0] x, input logic [15:0] y);
        logic [15:0][16:0] rows;
        logic [31:0]       acc;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 17; j++) begin
                rows[i][j] = row_bit(x, y, i, j);
            end
        end
        acc = '0;
        for (int i = 6; i < 16; i++) begin
            for (int j = 0; j < 17; j++) begin
                if (rows[i][j]) acc = acc + (32'd1 << (i + j));
            end
        end
        // The low six rows reach the product only through these pairs.
        acc = acc + corr_term(3, op_and, rows[0][2], rows[1][1]);
        acc = acc + corr_term(5, op_xor, rows[4][1], rows[5][0]);
        acc = acc + corr_term(6, op_and, rows[2][3], rows[3][2]);
        acc = acc + corr_term(7, op_xor, rows[0][7], rows[1][6]);
        acc = acc + corr_term(8, op_and, rows[0][7], rows[1][6]);
        acc = acc + corr_term(10, op_and, rows[2][7], rows[3][6]);
        acc = acc + corr_term(12, op_and, rows[0][11], rows[1][10]);
        acc = acc + corr_term(14, op_and, rows[0][13], rows[1][12]);
        acc = acc + corr_term(16, op_and, rows[0][15], rows[1][14]);
        acc = acc + corr_term(17, op_or, rows[1][15], 1'b0);
        acc = acc + corr_term(18, op_and, rows[2][15], rows[3][14]);
        acc = acc + corr_term(19, op_and, rows[4][14], rows[5][13]);
        acc = acc + corr_term(20, op_and, rows[4][15], rows[5][14]);
        acc = acc + corr_term(3, op_xor, rows[0][3], rows[1][2]);
        acc = acc + corr_term(7, op_and, rows[2][4], rows[3][3]);
        acc = acc + corr_term(8, op_xor, rows[0][8], rows[1][7]);
        acc = acc + corr_term(10, op_xor, rows[2][8], rows[3][7]);
        acc = acc + corr_term(14, op_and, rows[2][11], rows[3][10]);
        acc = acc + corr_term(17, op_or, rows[2][15], rows[3][14]);
        acc = acc + corr_term(18, op_or, rows[3][15], 1'b0);
        acc = acc + corr_term(19, op_xor, rows[4][15], rows[5][14]);
        acc = acc + corr_term(20, op_or, rows[5][15], 1'b0);
        acc = acc + corr_term(10, op_xor, rows[4][6], rows[5][5]);
        acc = acc + corr_term(14, op_xor, rows[4][10], rows[5][9]);
        acc = acc + corr_term(17, op_xor, rows[2][15], rows[3][14]);
        acc = acc + corr_term(18, op_and, rows[4][13], rows[5][12]);
        acc = acc + corr_term(17, op_xor, rows[4][13], rows[5][12]);
        acc = acc + corr_term(18, op_xor, rows[4][14], rows[5][13]);
        return acc;
    endfunction

    task automatic timeout_fail(input string what);
        $display("Timeout in test %s: no %s within %0d cycles", cur_test, what, timeout_cycles);
        timed_out = 1'b1;
    endtask

    task automatic send_request(input int len);
        int cycles;
        bit done;
        if (timed_out) return;
        cycles = 0;
        done = 1'b0;
        req_valid <= 1'b1;
        req.len   <= dot_pkg::len_w'(len);
        while (!done && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
            done = req_ready;
        end
        req_valid <= 1'b0;
        if (!done) timeout_fail("request transfer");
    endtask

    task automatic send_operands(input int gap_pct);
        int cycles;
        int gap;
        bit done;
        foreach (job_ops[b]) begin
            if (timed_out) return;
            gap = (int'(next_rand() % 100) < gap_pct) ? 1 + int'(next_rand() % 3) : 0;
            op_valid <= 1'b0;
            repeat (gap) @(posedge clk);
            op_valid <= 1'b1;
            op       <= job_ops[b];
            cycles = 0;
            done = 1'b0;
            while (!done && cycles < timeout_cycles) begin
                @(posedge clk);
                cycles++;
                done = op_ready;
            end
            if (!done) timeout_fail("operand transfer");
        end
        op_valid <= 1'b0;
    endtask

    task automatic take_result(input int bp_max);
        int cycles;
        int hold;
        bit done;
        if (timed_out) return;
        hold = (bp_max > 0) ? 1 + int'(next_rand() % bp_max) : 0;
        res_ready <= (hold == 0);
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
            if (res_valid && res_ready) begin
                done = 1'b1;
            end else if (res_valid) begin
                hold--;
                if (hold <= 0) res_ready <= 1'b1;
            end
        end
        res_ready <= 1'b0;
        if (done) jobs_done++;
        else timeout_fail("result transfer");
    endtask

    task automatic run_job(input int gap_pct, input int bp_max);
        send_request(job_ops.size());
        send_operands(gap_pct);
        take_result(bp_max);
        job_ops.delete();
    endtask

    task automatic fill_random(input int len);
        dot_pkg::operand_t o;
        logic [31:0]       r;
        repeat (len) begin
            r = next_rand();
            o.x = r[15:0];
            o.y = r[31:16];
            job_ops.push_back(o);
        end
    endtask

    task automatic fill_const(input logic [15:0] x, input logic [15:0] y, input int len);
        dot_pkg::operand_t o;
        o.x = x;
        o.y = y;
        repeat (len) job_ops.push_back(o);
    endtask

    task automatic single_job(input logic [15:0] x, input logic [15:0] y);
        fill_const(x, y, 1);
        run_job(0, 0);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        chk0.test_name = name;
        errors_at_start = chk0.error_count;
    endtask

    task automatic finish_test();
        int errs;
        // The checker counts at the rising edge, so its totals settle by the falling edge.
        @(negedge clk);
        errs = chk0.error_count - errors_at_start;
        tests_run++;
        if (timed_out || errs != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors%s", cur_test, errs,
                     timed_out ? " after a timeout" : "");
        end else begin
            $display("test %s: ok", cur_test);
        end
        @(posedge clk);
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        op_valid  = 1'b0;
        op        = '0;
        res_ready = 1'b0;

        start_test("reset_state");
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        finish_test();

        start_test("single_beat");
        single_job(16'h7fff, 16'h7fff);
        single_job(16'h8000, 16'h8000);
        single_job(16'h8000, 16'h7fff);
        single_job(16'h7fff, 16'h8000);
        single_job(16'h8001, 16'h7fff);
        single_job(16'h0000, 16'h8000);
        single_job(16'h0001, 16'h8001);
        single_job(16'h0001, 16'h0001);
        single_job(16'h0000, 16'h0000);
        finish_test();

        start_test("random_jobs");
        for (int j = 0; j < 20; j++) begin
            fill_random(1 + int'(next_rand() % 255));
            run_job(0, 0);
        end
        finish_test();

        start_test("operand_gaps");
        for (int j = 0; j < 6; j++) begin
            fill_random(1 + int'(next_rand() % 64));
            run_job(40, 0);
        end
        finish_test();

        start_test("result_backpressure");
        for (int j = 0; j < 6; j++) begin
            fill_random(1 + int'(next_rand() % 32));
            run_job(20, 12);
        end
        finish_test();

        // Largest products over the longest job reach the top bits of the 40-bit sum.
        start_test("accum_wrap");
        fill_const(16'h8000, 16'h8000, 255);
        run_job(0, 4);
        fill_const(16'h8000, 16'h7fff, 255);
        run_job(0, 4);
        finish_test();

        if (chk0.results_checked != jobs_done) begin
            $display("Checker saw %0d results but %0d jobs finished",
                     chk0.results_checked, jobs_done);
            tests_failed++;
        end
        $display("tests run %0d, failed %0d, jobs %0d, errors %0d",
                 tests_run, tests_failed, jobs_done, chk0.error_count);
        if (timed_out || tests_failed != 0 || chk0.error_count != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule
